/* Bender.yml */
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/icache_way.sv
  - design/icache_refill.sv
  - design/icache_ctrl.sv
  - design/icache_top.sv
  - target: test
    files:
      - test/icache_mem_model.sv
      - test/icache_tb.sv

/* design/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
  parameter int num_sets      = 64,
  parameter int fetch_credits = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  icache_pkg::fetch_req_t             fetch_req,
  output icache_pkg::fetch_rsp_t             fetch_rsp,
  output logic                               fetch_credit,
  output logic                               rd_en,
  output logic [icache_pkg::idx_w-1:0]       rd_idx,
  output logic [icache_pkg::tag_w-1:0]       cmp_tag,
  input  icache_pkg::way_rd_t                rd0,
  input  icache_pkg::way_rd_t                rd1,
  output logic                               fill_en0,
  output logic                               fill_en1,
  output logic [icache_pkg::idx_w-1:0]       fill_idx,
  output logic [icache_pkg::tag_w-1:0]       fill_tag,
  output icache_pkg::cache_line_t            fill_line,
  output logic                               refill_start,
  output logic [icache_pkg::line_addr_w-1:0] refill_addr,
  input  icache_pkg::cache_line_t            refill_line,
  input  logic                               refill_done
);
  import icache_pkg::*;

  localparam int cred_w = $clog2(fetch_credits + 1);

  // holding slot for a request that arrives during a miss
  logic                s1_valid_q;
  fetch_addr_t         s1_addr_q;
  logic                s2_valid_q;
  fetch_addr_t         s2_addr_q;
  logic                miss_q;
  logic                victim_q;
  // one bit per set, names the least recent way
  logic [num_sets-1:0] lru_q;
  logic                rsp_valid_q;
  logic                rsp_hit_q;
  logic [word_w-1:0]   rsp_data_q;
  logic [cred_w-1:0]   init_cnt_q;

  logic                rd_req;
  fetch_addr_t         rd_addr;
  logic                s2_hit;
  logic                hit_now;
  logic                miss_now;
  logic                stall;
  logic                victim;
  cache_line_t         hit_line;

  // held request goes first
  assign rd_req   = s1_valid_q | fetch_req.valid;
  assign rd_addr  = s1_valid_q ? s1_addr_q : fetch_req.addr;

  assign s2_hit   = rd0.hit | rd1.hit;
  assign hit_now  = s2_valid_q & ~miss_q & s2_hit;
  assign miss_now = s2_valid_q & ~miss_q & ~s2_hit;
  // also covers the fill edge, so a re-read sees the new line
  assign stall    = miss_now | miss_q;

  assign rd_en    = rd_req & ~stall;
  assign rd_idx   = rd_addr.idx;
  assign cmp_tag  = s2_addr_q.tag;
  assign hit_line = rd1.hit ? rd1.line : rd0.line;

  // invalid ways first, then lru
  always_comb begin
    if (!rd0.valid) begin
      victim = 1'b0;
    end else if (!rd1.valid) begin
      victim = 1'b1;
    end else begin
      victim = lru_q[s2_addr_q.idx];
    end
  end

  assign refill_start = miss_now;
  assign refill_addr  = {s2_addr_q.tag, s2_addr_q.idx};
  assign fill_en0     = refill_done & ~victim_q;
  assign fill_en1     = refill_done & victim_q;
  assign fill_idx     = s2_addr_q.idx;
  assign fill_tag     = s2_addr_q.tag;
  assign fill_line    = refill_line;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid_q  <= 1'b0;
      s2_valid_q  <= 1'b0;
      miss_q      <= 1'b0;
      lru_q       <= '0;
      rsp_valid_q <= 1'b0;
      init_cnt_q  <= cred_w'(fetch_credits);
    end else begin
      if (stall) begin
        s1_valid_q <= s1_valid_q | fetch_req.valid;
      end else begin
        s1_valid_q <= s1_valid_q & fetch_req.valid;
      end
      if (refill_done) begin
        s2_valid_q <= 1'b0;
      end else if (!stall) begin
        s2_valid_q <= rd_req;
      end
      if (miss_now) begin
        miss_q <= 1'b1;
      end else if (refill_done) begin
        miss_q <= 1'b0;
      end
      if (hit_now) begin
        lru_q[s2_addr_q.idx] <= rd0.hit;
      end else if (refill_done) begin
        lru_q[s2_addr_q.idx] <= ~victim_q;
      end
      rsp_valid_q <= hit_now | refill_done;
      // initial grants give way to response credits
      if (init_cnt_q != '0 && !rsp_valid_q) begin
        init_cnt_q <= init_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req.valid) begin
      s1_addr_q <= fetch_req.addr;
    end
    if (!stall) begin
      s2_addr_q <= rd_addr;
    end
    if (miss_now) begin
      victim_q <= victim;
    end
    rsp_hit_q <= hit_now;
    if (hit_now) begin
      rsp_data_q <= hit_line[s2_addr_q.off];
    end else if (refill_done) begin
      rsp_data_q <= refill_line[s2_addr_q.off];
    end
  end

  assign fetch_rsp.valid = rsp_valid_q;
  assign fetch_rsp.hit   = rsp_hit_q;
  assign fetch_rsp.data  = rsp_data_q;
  assign fetch_credit    = rsp_valid_q | (init_cnt_q != '0);

endmodule

/* design/icache_pkg.sv */
package icache_pkg;

  // geometry
  localparam int tag_w          = 21;
  localparam int idx_w          = 6;
  localparam int words_per_line = 4;
  localparam int word_w         = 64;
  localparam int off_w          = $clog2(words_per_line);
  localparam int byte_w         = 3;
  localparam int line_addr_w    = tag_w + idx_w;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [idx_w-1:0]  idx;
    logic [off_w-1:0]  off;
    logic [byte_w-1:0] byte_sel;
  } fetch_addr_t;

  // word 0 sits in the low 64 bits
  typedef logic [words_per_line-1:0][word_w-1:0] cache_line_t;

  typedef struct packed {
    logic        valid;
    fetch_addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    logic [word_w-1:0] data;
  } fetch_rsp_t;

  typedef struct packed {
    logic                   valid;
    logic [line_addr_w-1:0] line_addr;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] data;
  } mem_rsp_t;

  typedef struct packed {
    logic        hit;
    logic        valid;
    cache_line_t line;
  } way_rd_t;

endpackage

/* design/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               start,
  input  logic [icache_pkg::line_addr_w-1:0] line_addr,
  output icache_pkg::mem_req_t               mem_req,
  input  icache_pkg::mem_rsp_t               mem_rsp,
  output icache_pkg::cache_line_t            line,
  output logic                               line_done
);
  import icache_pkg::*;

  logic                   req_valid_q;
  logic [line_addr_w-1:0] req_addr_q;
  logic                   busy_q;
  logic [1:0]             beat_cnt_q;
  logic                   done_q;
  cache_line_t            buf_q;

  logic                   launch;
  logic                   beat_in;
  logic                   last_beat;

  assign launch    = start & ~busy_q;
  // stray beats with no request outstanding are dropped
  assign beat_in   = mem_rsp.valid & busy_q;
  assign last_beat = beat_in & (beat_cnt_q == 2'd3);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      beat_cnt_q  <= 2'd0;
      done_q      <= 1'b0;
    end else begin
      req_valid_q <= launch;
      done_q      <= last_beat;
      if (launch) begin
        busy_q <= 1'b1;
      end else if (last_beat) begin
        busy_q <= 1'b0;
      end
      if (last_beat) begin
        beat_cnt_q <= 2'd0;
      end else if (beat_in) begin
        beat_cnt_q <= beat_cnt_q + 2'd1;
      end
    end
  end

  // beats shift down, word 0 ends up lowest
  always_ff @(posedge clk) begin
    if (launch) begin
      req_addr_q <= line_addr;
    end
    if (beat_in) begin
      buf_q <= {mem_rsp.data, buf_q[words_per_line-1:1]};
    end
  end

  assign mem_req.valid     = req_valid_q;
  assign mem_req.line_addr = req_addr_q;
  assign line              = buf_q;
  assign line_done         = done_q;

endmodule

/* design/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
  parameter int num_sets      = 64,
  parameter int fetch_credits = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  icache_pkg::fetch_req_t fetch_req,
  output icache_pkg::fetch_rsp_t fetch_rsp,
  output logic                   fetch_credit,
  output icache_pkg::mem_req_t   mem_req,
  input  icache_pkg::mem_rsp_t   mem_rsp
);
  import icache_pkg::*;

  logic                   rd_en;
  logic [idx_w-1:0]       rd_idx;
  logic [tag_w-1:0]       cmp_tag;
  way_rd_t                rd0;
  way_rd_t                rd1;
  logic                   fill_en0;
  logic                   fill_en1;
  logic [idx_w-1:0]       fill_idx;
  logic [tag_w-1:0]       fill_tag;
  cache_line_t            fill_line;
  logic                   refill_start;
  logic [line_addr_w-1:0] refill_addr;
  cache_line_t            refill_line;
  logic                   refill_done;

  icache_way #(.num_sets(num_sets)) way0_i (
    .clk, .rst_n, .rd_en, .rd_idx, .cmp_tag,
    .fill_en(fill_en0), .fill_idx, .fill_tag, .fill_line,
    .rd(rd0)
  );

  icache_way #(.num_sets(num_sets)) way1_i (
    .clk, .rst_n, .rd_en, .rd_idx, .cmp_tag,
    .fill_en(fill_en1), .fill_idx, .fill_tag, .fill_line,
    .rd(rd1)
  );

  icache_ctrl #(
    .num_sets     (num_sets),
    .fetch_credits(fetch_credits)
  ) ctrl_i (
    .clk, .rst_n, .fetch_req, .fetch_rsp, .fetch_credit,
    .rd_en, .rd_idx, .cmp_tag, .rd0, .rd1,
    .fill_en0, .fill_en1, .fill_idx, .fill_tag, .fill_line,
    .refill_start, .refill_addr, .refill_line, .refill_done
  );

  icache_refill refill_i (
    .clk,
    .rst_n,
    .start    (refill_start),
    .line_addr(refill_addr),
    .mem_req,
    .mem_rsp,
    .line     (refill_line),
    .line_done(refill_done)
  );

endmodule

/* design/icache_way.sv */
`timescale 1ns/1ps

module icache_way #(
  parameter int num_sets = 64
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         rd_en,
  input  logic [icache_pkg::idx_w-1:0] rd_idx,
  input  logic [icache_pkg::tag_w-1:0] cmp_tag,
  input  logic                         fill_en,
  input  logic [icache_pkg::idx_w-1:0] fill_idx,
  input  logic [icache_pkg::tag_w-1:0] fill_tag,
  input  icache_pkg::cache_line_t      fill_line,
  output icache_pkg::way_rd_t          rd
);
  import icache_pkg::*;

  logic [num_sets-1:0] valid_q;
  logic [tag_w-1:0]    tag_mem [num_sets];
  cache_line_t         line_mem [num_sets];

  logic                rd_valid_q;
  logic [tag_w-1:0]    rd_tag_q;
  cache_line_t         rd_line_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (fill_en) begin
        valid_q[fill_idx] <= 1'b1;
      end
      if (rd_en) begin
        rd_valid_q <= valid_q[rd_idx];
      end
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_mem[fill_idx]  <= fill_tag;
      line_mem[fill_idx] <= fill_line;
    end
    if (rd_en) begin
      rd_tag_q  <= tag_mem[rd_idx];
      rd_line_q <= line_mem[rd_idx];
    end
  end

  // compare against the tag now in stage 2
  assign rd.hit   = rd_valid_q & (rd_tag_q == cmp_tag);
  assign rd.valid = rd_valid_q;
  assign rd.line  = rd_line_q;

endmodule

/* project.f */
design/icache_pkg.sv
design/icache_way.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

/* test/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  icache_pkg::mem_req_t mem_req,
  output icache_pkg::mem_rsp_t mem_rsp
);
  import icache_pkg::*;

  integer                 seed;
  logic [line_addr_w-1:0] pend_q [$];
  logic [line_addr_w-1:0] cur_addr;
  logic                   busy;
  int                     wait_cnt;
  int                     beat;

  // upper half is the beat's byte address, lower half its inverse
  function automatic logic [word_w-1:0] beat_word(input logic [line_addr_w-1:0] la,
                                                   input int k);
    logic [31:0] a;
    a = {la, 2'(k), 3'b000};
    return {a, ~a};
  endfunction

  initial begin
    seed     = 32'hbb45_458f;
    busy     = 1'b0;
    wait_cnt = 0;
    beat     = 0;
    mem_rsp  = '0;
  end

  always @(negedge clk) begin
    mem_rsp = '0;
    if (!rst_n) begin
      pend_q.delete();
      busy = 1'b0;
    end else begin
      if (mem_req.valid) begin
        pend_q.push_back(mem_req.line_addr);
      end
      if (!busy && pend_q.size() != 0) begin
        cur_addr = pend_q.pop_front();
        busy     = 1'b1;
        beat     = 0;
        wait_cnt = $unsigned($random(seed)) % 8;
      end else if (busy) begin
        if (wait_cnt != 0) begin
          wait_cnt--;
        end else begin
          mem_rsp.valid = 1'b1;
          mem_rsp.data  = beat_word(cur_addr, beat);
          beat++;
          // short random gap before the next beat
          wait_cnt = $unsigned($random(seed)) % 3;
          if (beat == words_per_line) begin
            busy = 1'b0;
          end
        end
      end
    end
  end

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam int num_sets      = 64;
  localparam int fetch_credits = 2;
  localparam int clk_period    = 40;
  localparam int num_reqs      = 400;

  typedef struct packed {
    logic              hit;
    logic [word_w-1:0] data;
  } exp_t;

  logic       clk;
  logic       rst_n;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  logic       fetch_credit;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;

  integer                 seed;
  int                     errors;
  int                     unexpected;
  int                     sent;
  int                     credits;
  logic                   credit_seen;
  int                     beats_due;
  exp_t                   exp_q [$];
  logic [line_addr_w-1:0] miss_q [$];

  // reference cache state
  logic             ref_valid [2][num_sets];
  logic [tag_w-1:0] ref_tag [2][num_sets];
  logic             ref_lru [num_sets];

  icache_top #(
    .num_sets     (num_sets),
    .fetch_credits(fetch_credits)
  ) icache_top_i (
    .clk, .rst_n, .fetch_req, .fetch_rsp, .fetch_credit, .mem_req, .mem_rsp
  );

  icache_mem_model mem_i (.clk, .rst_n, .mem_req, .mem_rsp);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] mk_addr(input logic [tag_w-1:0] tag,
                                          input logic [idx_w-1:0] idx,
                                          input logic [1:0] off,
                                          input logic [2:0] bsel);
    return {tag, idx, off, bsel};
  endfunction

  // expected word and hit flag from the reference state, kept in send order
  function automatic exp_t ref_fetch(input logic [31:0] a);
    logic [tag_w-1:0] tag;
    logic [idx_w-1:0] idx;
    logic [31:0]      wa;
    int               w;
    exp_t             e;
    tag    = a[31:11];
    idx    = a[10:5];
    wa     = {a[31:3], 3'b000};
    e.data = {wa, ~wa};
    if (ref_valid[0][idx] && ref_tag[0][idx] == tag) begin
      e.hit        = 1'b1;
      ref_lru[idx] = 1'b1;
    end else if (ref_valid[1][idx] && ref_tag[1][idx] == tag) begin
      e.hit        = 1'b1;
      ref_lru[idx] = 1'b0;
    end else begin
      e.hit = 1'b0;
      if (!ref_valid[0][idx]) w = 0;
      else if (!ref_valid[1][idx]) w = 1;
      else w = ref_lru[idx];
      ref_valid[w][idx] = 1'b1;
      ref_tag[w][idx]   = tag;
      ref_lru[idx]      = (w == 0);
      miss_q.push_back({tag, idx});
    end
    return e;
  endfunction

  // a credit seen at one falling edge is spent from the next one on
  task automatic tick();
    if (credit_seen) credits++;
    if (credits > fetch_credits) begin
      $display("requester holds %0d credits at %0t, more than were granted", credits, $time);
      errors++;
    end
    @(negedge clk);
    credit_seen     = fetch_credit;
    fetch_req.valid = 1'b0;
  endtask

  task automatic send_fetch(input logic [31:0] a);
    exp_t e;
    while (credits == 0) tick();
    e = ref_fetch(a);
    exp_q.push_back(e);
    fetch_req.valid = 1'b1;
    fetch_req.addr  = a;
    credits--;
    sent++;
    tick();
  endtask

  task automatic drain();
    while (exp_q.size() != 0) tick();
    repeat (3) tick();
  endtask

  always @(negedge clk) begin : compare
    exp_t e;
    if (rst_n && fetch_rsp.valid) begin
      if (!fetch_credit) begin
        $display("ERROR %0t fetch_credit expected 1 got 0", $time);
        errors++;
      end
      if (exp_q.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        unexpected++;
      end else begin
        e = exp_q.pop_front();
        if (fetch_rsp.hit !== e.hit) begin
          $display("ERROR %0t fetch_rsp.hit expected %b got %b", $time, e.hit, fetch_rsp.hit);
          errors++;
        end
        if (fetch_rsp.data !== e.data) begin
          $display("ERROR %0t fetch_rsp.data expected %h got %h", $time, e.data,
                   fetch_rsp.data);
          errors++;
        end
      end
    end
  end

  always @(negedge clk) begin : mem_watch
    logic [line_addr_w-1:0] la;
    if (rst_n && mem_req.valid) begin
      if (beats_due != 0) begin
        $display("second mem_req at %0t before the previous line came back", $time);
        errors++;
      end
      if (miss_q.size() == 0) begin
        $display("mem_req at %0t without a missing fetch", $time);
        errors++;
      end else begin
        la = miss_q.pop_front();
        if (mem_req.line_addr !== la) begin
          $display("ERROR %0t mem_req.line_addr expected %h got %h", $time, la,
                   mem_req.line_addr);
          errors++;
        end
      end
      beats_due = words_per_line;
    end
  end

  always @(posedge clk) begin
    if (rst_n && mem_rsp.valid && beats_due > 0) beats_due--;
  end

  initial begin : stimulus
    logic [31:0] r;
    seed        = 32'hbb45_458f;
    errors      = 0;
    unexpected  = 0;
    sent        = 0;
    credits     = 0;
    credit_seen = 1'b0;
    beats_due   = 0;
    fetch_req   = '0;
    rst_n       = 1'b0;
    for (int s = 0; s < num_sets; s++) begin
      ref_valid[0][s] = 1'b0;
      ref_valid[1][s] = 1'b0;
      ref_lru[s]      = 1'b0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    // the cycle that releases reset already carries a grant
    credit_seen = fetch_credit;
    repeat (4) tick();
    if (credits != fetch_credits) begin
      $display("ERROR %0t fetch_credit pulses expected %0d got %0d", $time, fetch_credits,
               credits);
      errors++;
    end
    // cold miss, then hits across all four words
    send_fetch(mk_addr(21'h01234, 6'd5, 2'd1, 3'd0));
    drain();
    for (int k = 0; k < 4; k++) send_fetch(mk_addr(21'h01234, 6'd5, 2'(k), 3'd0));
    drain();
    // A B A C A B in one set where C evicts B
    send_fetch(mk_addr(21'h00a11, 6'd9, 2'd0, 3'd0));
    send_fetch(mk_addr(21'h00b22, 6'd9, 2'd1, 3'd0));
    send_fetch(mk_addr(21'h00a11, 6'd9, 2'd2, 3'd0));
    send_fetch(mk_addr(21'h00c33, 6'd9, 2'd3, 3'd0));
    send_fetch(mk_addr(21'h00a11, 6'd9, 2'd3, 3'd0));
    send_fetch(mk_addr(21'h00b22, 6'd9, 2'd0, 3'd0));
    drain();
    // hit right behind a miss
    send_fetch(mk_addr(21'h00d44, 6'd5, 2'd0, 3'd0));
    send_fetch(mk_addr(21'h01234, 6'd5, 2'd2, 3'd0));
    drain();
    while (sent < num_reqs) begin
      r = $random(seed);
      send_fetch(mk_addr(21'h15a00 + 21'(r[10:9]) * 21'h00301, 6'd20 + 6'(r[3:2]),
                         r[5:4], r[8:6]));
    end
    drain();
    if (credits != fetch_credits) begin
      $display("ERROR %0t fetch_credit count expected %0d got %0d", $time, fetch_credits,
               credits);
      errors++;
    end
    if (miss_q.size() != 0 || beats_due != 0) begin
      $display("%0d misses never raised mem_req, %0d beats missing", miss_q.size(), beats_due);
      errors++;
    end
    $display("%0d requests, %0d errors, %0d unexpected responses", sent, errors, unexpected);
    if (errors == 0 && unexpected == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(num_reqs * 40 * clk_period);
    $display("timeout at %0t, the cache hung with %0d responses outstanding", $time,
             exp_q.size());
    $display("Test FAILED");
    $finish;
  end

endmodule
